/* logic/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

  // RV32E register space
  localparam int REG_IDX_W = 4;
  localparam int NUM_REGS  = 16;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // ALU operation, low bits follow funct3, top bit picks SUB/SRA
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SRA  = 4'b1101;

  // Major opcodes kept by this slice
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;

  // funct3 values where funct7 bit 5 changes the operation
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;

  // Instruction field positions, RV32E uses the low four index bits
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_B5  = 30;

endpackage

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file #(
  parameter int XLEN = 32
) (
  input  wire                      clk,
  input  wire                      rst,
  input  rv_decode_pkg::reg_idx_t  rd_addr1_i,
  input  rv_decode_pkg::reg_idx_t  rd_addr2_i,
  output logic [XLEN-1:0]          rd_data1_o,
  output logic [XLEN-1:0]          rd_data2_o,
  input  wire                      wr_en_i,
  input  rv_decode_pkg::reg_idx_t  wr_addr_i,
  input  wire  [XLEN-1:0]          wr_data_i
);
  import rv_decode_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // x0 always reads as zero
  always_comb begin
    rd_data1_o = (rd_addr1_i == '0) ? '0 : regs[rd_addr1_i];
    rd_data2_o = (rd_addr2_i == '0) ? '0 : regs[rd_addr2_i];
  end

endmodule

`default_nettype wire

/* logic/busy_table.sv */
`default_nettype none

module busy_table (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  set_i,
  input  rv_decode_pkg::reg_idx_t              set_idx_i,
  input  wire                                  clr_i,
  input  rv_decode_pkg::reg_idx_t              clr_idx_i,
  output logic [rv_decode_pkg::NUM_REGS-1:0]   busy_o
);
  import rv_decode_pkg::*;

  logic [NUM_REGS-1:0] busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (clr_i) begin
        busy_q[clr_idx_i] <= 1'b0;
      end
      // Issue of a new producer wins over the retire of the old one
      if (set_i && (set_idx_i != '0)) begin
        busy_q[set_idx_i] <= 1'b1;
      end
    end
  end

  assign busy_o = busy_q;

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none

module decode_stage #(
  parameter int XLEN = 32
) (
  input  wire                                 clk,
  input  wire                                 rst,

  input  wire                                 fetch_valid_i,
  output logic                                fetch_ready_o,
  input  wire  [31:0]                         inst_i,
  input  wire  [XLEN-1:0]                     pc_i,

  output rv_decode_pkg::reg_idx_t             rf_addr1_o,
  output rv_decode_pkg::reg_idx_t             rf_addr2_o,
  input  wire  [XLEN-1:0]                     rf_data1_i,
  input  wire  [XLEN-1:0]                     rf_data2_i,
  input  wire  [rv_decode_pkg::NUM_REGS-1:0]  busy_i,

  input  wire                                 fwd_valid_i,
  input  rv_decode_pkg::reg_idx_t             fwd_rd_i,
  input  wire  [XLEN-1:0]                     fwd_data_i,

  output logic                                dec_valid_o,
  input  wire                                 exec_ready_i,
  output logic [XLEN-1:0]                     op1_o,
  output logic [XLEN-1:0]                     op2_o,
  output rv_decode_pkg::alu_op_t              alu_op_o,
  output rv_decode_pkg::reg_idx_t             rd_o,
  output logic [XLEN-1:0]                     pc_o,
  output logic                                illegal_o,
  output logic                                issue_o
);
  import rv_decode_pkg::*;

  logic            valid_q;
  logic [31:0]     inst_q;
  logic [XLEN-1:0] pc_q;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            funct7_b5;
  reg_idx_t        rs1;
  reg_idx_t        rs2;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic            fwd_hit1;
  logic            fwd_hit2;
  logic            use_rs1;
  logic            use_rs2;
  logic            hazard;
  logic            fetch_xfer;

  // Instruction register
  assign fetch_xfer = fetch_valid_i & fetch_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (fetch_ready_o) begin
      valid_q <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // Fields
  assign opcode    = inst_q[6:0];
  assign funct3    = inst_q[FUNCT3_LSB +: 3];
  assign funct7_b5 = inst_q[FUNCT7_B5];
  assign rs1       = inst_q[RS1_LSB +: REG_IDX_W];
  assign rs2       = inst_q[RS2_LSB +: REG_IDX_W];
  assign rd_o      = inst_q[RD_LSB +: REG_IDX_W];

  // Immediates sign-extended to XLEN
  assign imm_i = XLEN'($signed(inst_q[31:20]));
  assign imm_u = XLEN'($signed({inst_q[31:12], 12'b0}));

  assign rf_addr1_o = rs1;
  assign rf_addr2_o = rs2;

  // Result in the ALU register is newer than the register file
  assign fwd_hit1 = fwd_valid_i && (fwd_rd_i == rs1);
  assign fwd_hit2 = fwd_valid_i && (fwd_rd_i == rs2);
  assign rs1_val  = fwd_hit1 ? fwd_data_i : rf_data1_i;
  assign rs2_val  = fwd_hit2 ? fwd_data_i : rf_data2_i;

  always_comb begin
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    illegal_o = 1'b0;
    op1_o     = rs1_val;
    op2_o     = imm_i;
    alu_op_o  = ALU_ADD;
    case (opcode)
      OP_LUI: begin
        op1_o = '0;
        op2_o = imm_u;
      end
      OP_AUIPC: begin
        op1_o = pc_q;
        op2_o = imm_u;
      end
      OP_IMM: begin
        // funct7 bit 5 only selects SRAI here, ADDI has no SUB form
        use_rs1  = 1'b1;
        alu_op_o = {(funct3 == F3_SRL_SRA) & funct7_b5, funct3};
      end
      OP_REG: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        op2_o    = rs2_val;
        alu_op_o = {((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)) & funct7_b5, funct3};
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

  // Stall when a source is still in flight and not on the forward path
  assign hazard = valid_q && ((use_rs1 && busy_i[rs1] && !fwd_hit1) ||
                              (use_rs2 && busy_i[rs2] && !fwd_hit2));

  assign dec_valid_o   = valid_q & ~hazard;
  assign fetch_ready_o = ~valid_q | (exec_ready_i & ~hazard);
  assign pc_o          = pc_q;

  // Busy bit of rd is claimed when the instruction leaves decode
  assign issue_o = dec_valid_o & exec_ready_i & ~illegal_o;

endmodule

`default_nettype wire

/* logic/exec_stage.sv */
`default_nettype none

module exec_stage #(
  parameter int XLEN = 32
) (
  input  wire                      clk,
  input  wire                      rst,

  input  wire                      dec_valid_i,
  output logic                     exec_ready_o,
  input  wire  [XLEN-1:0]          op1_i,
  input  wire  [XLEN-1:0]          op2_i,
  input  rv_decode_pkg::alu_op_t   alu_op_i,
  input  rv_decode_pkg::reg_idx_t  rd_i,
  input  wire  [XLEN-1:0]          pc_i,
  input  wire                      illegal_i,

  output logic                     fwd_valid_o,
  output rv_decode_pkg::reg_idx_t  fwd_rd_o,
  output logic [XLEN-1:0]          fwd_data_o,

  output logic                     retire_valid_o,
  input  wire                      retire_ready_i,
  output rv_decode_pkg::reg_idx_t  retire_rd_o,
  output logic [XLEN-1:0]          retire_data_o,
  output logic [XLEN-1:0]          retire_pc_o,
  output logic                     retire_illegal_o
);
  import rv_decode_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] result;
  logic            ret_load;

  logic            alu_valid_q;
  reg_idx_t        alu_rd_q;
  logic [XLEN-1:0] alu_data_q;
  logic [XLEN-1:0] alu_pc_q;
  logic            alu_illegal_q;

  assign shamt = op2_i[SHW-1:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result = op1_i + op2_i;
      ALU_SUB:  result = op1_i - op2_i;
      ALU_SLL:  result = op1_i << shamt;
      ALU_SLT:  result = XLEN'($signed(op1_i) < $signed(op2_i));
      ALU_SLTU: result = XLEN'(op1_i < op2_i);
      ALU_XOR:  result = op1_i ^ op2_i;
      ALU_SRL:  result = op1_i >> shamt;
      ALU_SRA:  result = $signed(op1_i) >>> shamt;
      ALU_OR:   result = op1_i | op2_i;
      ALU_AND:  result = op1_i & op2_i;
      default:  result = '0;
    endcase
  end

  // Retire register takes a new entry when empty or draining this cycle
  assign ret_load     = alu_valid_q & (~retire_valid_o | retire_ready_i);
  assign exec_ready_o = ~alu_valid_q | ret_load;

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid_q    <= 1'b0;
      retire_valid_o <= 1'b0;
    end else begin
      if (exec_ready_o) begin
        alu_valid_q <= dec_valid_i;
      end
      if (~retire_valid_o | retire_ready_i) begin
        retire_valid_o <= alu_valid_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid_i && exec_ready_o) begin
      alu_rd_q      <= rd_i;
      alu_data_q    <= result;
      alu_pc_q      <= pc_i;
      alu_illegal_q <= illegal_i;
    end
    if (ret_load) begin
      retire_rd_o      <= alu_rd_q;
      retire_data_o    <= alu_data_q;
      retire_pc_o      <= alu_pc_q;
      retire_illegal_o <= alu_illegal_q;
    end
  end

  assign fwd_valid_o = alu_valid_q & ~alu_illegal_q & (alu_rd_q != '0);
  assign fwd_rd_o    = alu_rd_q;
  assign fwd_data_o  = alu_data_q;

endmodule

`default_nettype wire

/* logic/decode_exec_top.sv */
`default_nettype none

module decode_exec_top #(
  parameter int XLEN = 32
) (
  input  wire                      clk,
  input  wire                      rst,

  input  wire                      fetch_valid_i,
  output logic                     fetch_ready_o,
  input  wire  [31:0]              inst_i,
  input  wire  [XLEN-1:0]          pc_i,

  output logic                     retire_valid_o,
  input  wire                      retire_ready_i,
  output rv_decode_pkg::reg_idx_t  retire_rd_o,
  output logic [XLEN-1:0]          retire_data_o,
  output logic [XLEN-1:0]          retire_pc_o,
  output logic                     retire_illegal_o
);
  import rv_decode_pkg::*;

  reg_idx_t              rf_addr1;
  reg_idx_t              rf_addr2;
  logic [XLEN-1:0]       rf_data1;
  logic [XLEN-1:0]       rf_data2;
  logic                  rf_wr_en;
  logic [NUM_REGS-1:0]   busy;
  logic                  busy_clr;
  logic                  issue;

  logic                  fwd_valid;
  reg_idx_t              fwd_rd;
  logic [XLEN-1:0]       fwd_data;

  logic                  dec_valid;
  logic                  exec_ready;
  logic [XLEN-1:0]       op1;
  logic [XLEN-1:0]       op2;
  alu_op_t               alu_op;
  reg_idx_t              dec_rd;
  logic [XLEN-1:0]       dec_pc;
  logic                  dec_illegal;

  assign rf_wr_en = retire_valid_o & retire_ready_i & ~retire_illegal_o &
                    (retire_rd_o != '0);

  // Keep the bit set while a younger writer of the same rd sits in the ALU register
  assign busy_clr = rf_wr_en & ~(fwd_valid & (fwd_rd == retire_rd_o));

  reg_file #(.XLEN(XLEN)) u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .rd_addr1_i (rf_addr1),
    .rd_addr2_i (rf_addr2),
    .rd_data1_o (rf_data1),
    .rd_data2_o (rf_data2),
    .wr_en_i    (rf_wr_en),
    .wr_addr_i  (retire_rd_o),
    .wr_data_i  (retire_data_o)
  );

  busy_table u_busy_table (
    .clk       (clk),
    .rst       (rst),
    .set_i     (issue),
    .set_idx_i (dec_rd),
    .clr_i     (busy_clr),
    .clr_idx_i (retire_rd_o),
    .busy_o    (busy)
  );

  decode_stage #(.XLEN(XLEN)) u_decode (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .rf_addr1_o    (rf_addr1),
    .rf_addr2_o    (rf_addr2),
    .rf_data1_i    (rf_data1),
    .rf_data2_i    (rf_data2),
    .busy_i        (busy),
    .fwd_valid_i   (fwd_valid),
    .fwd_rd_i      (fwd_rd),
    .fwd_data_i    (fwd_data),
    .dec_valid_o   (dec_valid),
    .exec_ready_i  (exec_ready),
    .op1_o         (op1),
    .op2_o         (op2),
    .alu_op_o      (alu_op),
    .rd_o          (dec_rd),
    .pc_o          (dec_pc),
    .illegal_o     (dec_illegal),
    .issue_o       (issue)
  );

  exec_stage #(.XLEN(XLEN)) u_exec (
    .clk              (clk),
    .rst              (rst),
    .dec_valid_i      (dec_valid),
    .exec_ready_o     (exec_ready),
    .op1_i            (op1),
    .op2_i            (op2),
    .alu_op_i         (alu_op),
    .rd_i             (dec_rd),
    .pc_i             (dec_pc),
    .illegal_i        (dec_illegal),
    .fwd_valid_o      (fwd_valid),
    .fwd_rd_o         (fwd_rd),
    .fwd_data_o       (fwd_data),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_pc_o      (retire_pc_o),
    .retire_illegal_o (retire_illegal_o)
  );

endmodule

`default_nettype wire

/* bench/decode_exec_asserts.sv */
`default_nettype none

module decode_exec_asserts #(
  parameter int XLEN = 32
) (
  input wire                                 clk,
  input wire                                 rst,
  input wire                                 fetch_ready_i,
  input wire                                 hazard_i,
  input wire                                 retire_valid_i,
  input wire                                 retire_ready_i,
  input rv_decode_pkg::reg_idx_t             retire_rd_i,
  input wire [XLEN-1:0]                      retire_data_i,
  input wire [XLEN-1:0]                      retire_pc_i,
  input wire                                 retire_illegal_i,
  input wire [rv_decode_pkg::NUM_REGS-1:0]   busy_i
);
  import rv_decode_pkg::*;

  // Retire entry must not move while the consumer stalls
  retire_hold: assert property (@(posedge clk) disable iff (rst)
    retire_valid_i && !retire_ready_i |=> retire_valid_i && $stable(retire_rd_i) &&
      $stable(retire_data_i) && $stable(retire_pc_i) && $stable(retire_illegal_i))
    else $error("retire outputs changed while stalled");

  // A source not on the forward path can only be waiting on the retire register
  hazard_stall: assert property (@(posedge clk) disable iff (rst)
    hazard_i |-> !fetch_ready_i && retire_valid_i)
    else $error("fetch_ready_o high or retire register empty during a hazard");

  x0_free: assert property (@(posedge clk) disable iff (rst) !busy_i[0])
    else $error("busy bit set for x0");

endmodule

bind decode_exec_top decode_exec_asserts #(.XLEN(XLEN)) u_asserts (
  .clk              (clk),
  .rst              (rst),
  .fetch_ready_i    (fetch_ready_o),
  .hazard_i         (u_decode.hazard),
  .retire_valid_i   (retire_valid_o),
  .retire_ready_i   (retire_ready_i),
  .retire_rd_i      (retire_rd_o),
  .retire_data_i    (retire_data_o),
  .retire_pc_i      (retire_pc_o),
  .retire_illegal_i (retire_illegal_o),
  .busy_i           (busy)
);

`default_nettype wire

/* bench/decode_exec_tb.sv */
`default_nettype none

module decode_exec_tb;
  import rv_decode_pkg::*;

  localparam int XLEN    = 32;
  localparam int NUM_PAT = 22;
  localparam int TIMEOUT = 500;

  logic            clk = 1'b0;
  logic            rst;
  logic            fetch_valid;
  logic            fetch_ready;
  logic [31:0]     inst;
  logic [XLEN-1:0] pc;
  logic            retire_valid;
  logic            retire_ready;
  reg_idx_t        retire_rd;
  logic [XLEN-1:0] retire_data;
  logic [XLEN-1:0] retire_pc;
  logic            retire_illegal;

  // Five words per pattern line
  logic [31:0]     pat_mem [NUM_PAT*5];
  reg_idx_t        exp_rd_q[$];
  logic [XLEN-1:0] exp_data_q[$];
  logic [XLEN-1:0] exp_pc_q[$];
  logic            exp_ill_q[$];

  int seed = 32'he47f_f82e;
  int check_errs = 0;
  int other_errs = 0;
  int retired = 0;
  bit abort = 1'b0;

  decode_exec_top #(.XLEN(XLEN)) u_dut (
    .clk              (clk),
    .rst              (rst),
    .fetch_valid_i    (fetch_valid),
    .fetch_ready_o    (fetch_ready),
    .inst_i           (inst),
    .pc_i             (pc),
    .retire_valid_o   (retire_valid),
    .retire_ready_i   (retire_ready),
    .retire_rd_o      (retire_rd),
    .retire_data_o    (retire_data),
    .retire_pc_o      (retire_pc),
    .retire_illegal_o (retire_illegal)
  );

  always #5 clk = ~clk;

  // Consumer ready about 70 % of the cycles
  always @(posedge clk) begin
    #1;
    retire_ready = ({$random(seed)} % 10) < 7;
  end

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
      check_errs++;
    end
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      check_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      check_errs++;
    end
  endtask

  task automatic load_patterns();
    $readmemh("bench/decode_exec_patterns.txt", pat_mem);
    if (pat_mem[NUM_PAT*5-1] === 'x) begin
      $display("Pattern file is missing or holds fewer than %0d lines", NUM_PAT);
      other_errs++;
      abort = 1'b1;
    end
    for (int i = 0; i < NUM_PAT; i++) begin
      exp_pc_q.push_back(pat_mem[i*5+1]);
      exp_rd_q.push_back(pat_mem[i*5+2][3:0]);
      exp_data_q.push_back(pat_mem[i*5+3]);
      exp_ill_q.push_back(pat_mem[i*5+4][0]);
    end
  endtask

  // Called just after a rising edge, returns just after the transfer edge
  task automatic send_inst(input logic [31:0] word, input logic [XLEN-1:0] addr);
    int waited;
    waited = 0;
    fetch_valid = 1'b1;
    inst = word;
    pc = addr;
    @(negedge clk);
    while (!fetch_ready && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!fetch_ready) begin
      $display("Timeout: fetch_ready_o stayed low with the instruction at pc %h", addr);
      other_errs++;
      abort = 1'b1;
    end else begin
      @(posedge clk);
      #1;
    end
  endtask

  // Retire handshake happens on the next rising edge
  always @(negedge clk) begin
    if (!rst && retire_valid && retire_ready) begin
      if (retired >= NUM_PAT) begin
        $display("Extra retire at t=%0t with pc %h", $time, retire_pc);
        other_errs++;
      end else begin
        check_idx("retire_rd_o", retire_rd, exp_rd_q[retired]);
        check_data("retire_pc_o", retire_pc, exp_pc_q[retired]);
        check_flag("retire_illegal_o", retire_illegal, exp_ill_q[retired]);
        if (!exp_ill_q[retired]) begin
          check_data("retire_data_o", retire_data, exp_data_q[retired]);
        end
      end
      retired++;
    end
  end

  initial begin
    int waited;
    rst = 1'b1;
    fetch_valid = 1'b0;
    inst = '0;
    pc = '0;
    retire_ready = 1'b0;
    load_patterns();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_flag("retire_valid_o", retire_valid, 1'b0);
    check_flag("fetch_ready_o", fetch_ready, 1'b1);
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_PAT && !abort; i++) begin
      send_inst(pat_mem[i*5], pat_mem[i*5+1]);
    end
    fetch_valid = 1'b0;
    waited = 0;
    while (retired < NUM_PAT && waited < TIMEOUT && !abort) begin
      waited++;
      @(posedge clk);
    end
    if (retired < NUM_PAT) begin
      $display("Timeout: only %0d of %0d instructions retired", retired, NUM_PAT);
      other_errs++;
    end
    // A few idle cycles to catch duplicated retires
    repeat (10) @(posedge clk);
    $display("Check errors: %0d, other errors: %0d, retired: %0d of %0d",
             check_errs, other_errs, retired, NUM_PAT);
    if (check_errs == 0 && other_errs == 0 && retired == NUM_PAT) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
logic/rv_decode_pkg.sv
logic/reg_file.sv
logic/busy_table.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/decode_exec_top.sv
bench/decode_exec_asserts.sv
bench/decode_exec_tb.sv

/* Makefile */
TOP = decode_exec_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* bench/decode_exec_patterns.txt */
// Columns: instruction, pc, expected rd, expected data, expected illegal flag
// Data of an illegal entry is not compared
123450B7 00000100 1 12345000 0
00001117 00000104 2 00001104 0
00500193 00000108 3 00000005 0
00718193 0000010C 3 0000000C 0
FFF18193 00000110 3 0000000B 0
40118233 00000114 4 EDCBB00B 0
800002B7 00000118 5 80000000 0
40328333 0000011C 6 7FFFFFF5 0
4042D393 00000120 7 F8000000 0
0042D413 00000124 8 08000000 0
4032D4B3 00000128 9 FFF00000 0
0032A533 0000012C A 00000001 0
0032B5B3 00000130 B 00000000 0
0FF0C613 00000134 C 123450FF 0
002666B3 00000138 D 123451FF 0
FF06F713 0000013C E 123451F0 0
003197B3 00000140 F 00005800 0
0000A203 00000144 4 00000000 1
00020793 00000148 F EDCBB00B 0
00108013 0000014C 0 12345001 0
000000B3 00000150 1 00000000 0
00308113 00000154 2 00000003 0
